// File: aesCore.f
+incdir+dv
hdl/aesPkg.sv
hdl/aesRoundIf.sv
hdl/aesEncRound.sv
hdl/aesDecRound.sv
hdl/aesControl.sv
hdl/aesKeySchedule.sv
hdl/aesRoundEngine.sv
hdl/aesCore.sv
dv/aesCore_chk.sv
dv/aesCoreTb.sv

// File: dv/aesModel.svh
`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

// software AES-128 where byte n sits at row n%4 and column n/4 with byte 0 in the top bits
localparam logic [7:0] modelAffine = 8'h63;

logic [7:0] modelSbox [256];
logic [7:0] modelInvSbox [256];

// carryless product, then reduction by x^8 + x^4 + x^3 + x + 1
function automatic logic [7:0] mulModel(input logic [7:0] a, input logic [7:0] b);
	logic [15:0] prod;
	prod = '0;
	for (int i = 0; i < 8; i++) begin
		if (b[i]) begin
			prod = prod ^ (16'(a) << i);
		end
	end
	for (int i = 15; i >= 8; i--) begin
		if (prod[i]) begin
			prod = prod ^ (16'h011b << (i - 8));
		end
	end
	return prod[7:0];
endfunction

// inverse by brute-force search, then the affine map bit by bit
task automatic buildModelTables();
	logic [7:0] inv;
	logic [7:0] s;
	for (int a = 0; a < 256; a++) begin
		inv = 8'h00;
		for (int b = 1; b < 256; b++) begin
			if (mulModel(8'(a), 8'(b)) == 8'h01) begin
				inv = 8'(b);
			end
		end
		for (int i = 0; i < 8; i++) begin
			s[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^ inv[(i + 6) % 8]
				^ inv[(i + 7) % 8] ^ modelAffine[i];
		end
		modelSbox[a] = s;
		modelInvSbox[s] = 8'(a);
	end
endtask

function automatic logic [7:0] byteAt(input logic [127:0] s, input int r, input int c);
	return s[127 - 8*(4*c + r) -: 8];
endfunction

function automatic logic [127:0] subModel(input logic [127:0] s, input logic inv);
	logic [127:0] res;
	for (int n = 0; n < 16; n++) begin
		res[127 - 8*n -: 8] = inv ? modelInvSbox[s[127 - 8*n -: 8]]
			: modelSbox[s[127 - 8*n -: 8]];
	end
	return res;
endfunction

function automatic logic [127:0] shiftModel(input logic [127:0] s, input logic inv);
	logic [127:0] res;
	for (int c = 0; c < 4; c++) begin
		for (int r = 0; r < 4; r++) begin
			res[127 - 8*(4*c + r) -: 8] = byteAt(s, r, inv ? (c - r + 4) % 4 : (c + r) % 4);
		end
	end
	return res;
endfunction

function automatic logic [127:0] mixModel(input logic [127:0] s, input logic inv);
	logic [7:0] coef [4];
	logic [7:0] acc;
	logic [127:0] res;
	coef[0] = inv ? 8'h0e : 8'h02;
	coef[1] = inv ? 8'h0b : 8'h03;
	coef[2] = inv ? 8'h0d : 8'h01;
	coef[3] = inv ? 8'h09 : 8'h01;
	for (int c = 0; c < 4; c++) begin
		for (int r = 0; r < 4; r++) begin
			acc = '0;
			for (int j = 0; j < 4; j++) begin
				acc = acc ^ mulModel(coef[j], byteAt(s, (r + j) % 4, c));
			end
			res[127 - 8*(4*c + r) -: 8] = acc;
		end
	end
	return res;
endfunction

// round key n expanded from scratch on each call
function automatic logic [127:0] roundKeyModel(input logic [127:0] key, input int n);
	logic [127:0] rk;
	logic [31:0] t;
	logic [7:0] rc;
	rk = key;
	rc = 8'h01;
	for (int r = 1; r <= n; r++) begin
		t = rk[31:0];
		t = {modelSbox[t[23:16]], modelSbox[t[15:8]], modelSbox[t[7:0]], modelSbox[t[31:24]]};
		rk[127:96] = rk[127:96] ^ t ^ {rc, 24'h000000};
		rk[95:64] = rk[95:64] ^ rk[127:96];
		rk[63:32] = rk[63:32] ^ rk[95:64];
		rk[31:0] = rk[31:0] ^ rk[63:32];
		rc = mulModel(rc, 8'h02);
	end
	return rk;
endfunction

function automatic logic [127:0] encryptModel(input logic [127:0] key, input logic [127:0] pt);
	logic [127:0] s;
	s = pt ^ roundKeyModel(key, 0);
	for (int rnd = 1; rnd <= 10; rnd++) begin
		s = shiftModel(subModel(s, 1'b0), 1'b0);
		if (rnd != 10) begin
			s = mixModel(s, 1'b0);
		end
		s = s ^ roundKeyModel(key, rnd);
	end
	return s;
endfunction

function automatic logic [127:0] decryptModel(input logic [127:0] key, input logic [127:0] ct);
	logic [127:0] s;
	s = ct ^ roundKeyModel(key, 10);
	for (int rnd = 9; rnd >= 0; rnd--) begin
		s = subModel(shiftModel(s, 1'b1), 1'b1) ^ roundKeyModel(key, rnd);
		if (rnd != 0) begin
			s = mixModel(s, 1'b1);
		end
	end
	return s;
endfunction

`endif

// File: dv/aesCoreTb.sv
`timescale 1ns/1ps

module aesCoreTb;

	`include "aesModel.svh"

	localparam int numRandom = 40;
	// known vector pair, random pairs plus round trips, busy test, two aborted ops and a restart
	localparam int numOps = 2 + 3*numRandom + 4;
	localparam int cycleLimit = numOps*30 + 100;
	localparam logic [127:0] knownKey = 128'h000102030405060708090a0b0c0d0e0f;
	localparam logic [127:0] knownPt = 128'h00112233445566778899aabbccddeeff;
	localparam logic [127:0] knownCt = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

	logic clk;
	logic rst;
	logic start;
	logic decrypt;
	logic [127:0] keyIn;
	logic [127:0] blockIn;
	logic [127:0] blockOut;
	logic busy;
	logic done;

	int errors = 0;
	int checks = 0;
	int cycleCount = 0;
	logic [31:0] lfsrState = 32'd54;

	aesCore u_dut (
		.clk(clk),
		.rst(rst),
		.start(start),
		.decrypt(decrypt),
		.keyIn(keyIn),
		.blockIn(blockIn),
		.blockOut(blockOut),
		.busy(busy),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic checkValue(input logic [127:0] got, input logic [127:0] exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, got, exp);
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic takeBits(input int n, output logic [127:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			val = {val[126:0], lfsrState[0]};
		end
	endtask

	// returns just after the edge that accepts start
	task automatic startOp(input logic [127:0] key, input logic [127:0] blk, input logic dec);
		@(posedge clk);
		start <= 1'b1;
		keyIn <= key;
		blockIn <= blk;
		decrypt <= dec;
		@(posedge clk);
		start <= 1'b0;
	endtask

	// injectAt raises a second start that many edges into the operation
	task automatic runOp(input logic [127:0] key, input logic [127:0] blk, input logic dec,
			input int injectAt, output logic [127:0] res);
		int edges;
		logic [127:0] junkKey;
		logic [127:0] junkBlk;
		logic [127:0] junkDir;
		startOp(key, blk, dec);
		edges = 0;
		@(negedge clk);
		while (!done && edges <= 40) begin
			checkValue(128'(busy), 128'(1), "busy low while in flight");
			@(posedge clk);
			edges++;
			if (edges == injectAt) begin
				takeBits(128, junkKey);
				takeBits(128, junkBlk);
				takeBits(1, junkDir);
				start <= 1'b1;
				keyIn <= junkKey;
				blockIn <= junkBlk;
				decrypt <= junkDir[0];
			end else begin
				start <= 1'b0;
			end
			@(negedge clk);
		end
		checkValue(128'(edges), 128'(21), "edges from start to done");
		res = blockOut;
	endtask

	initial begin
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout: run did not finish within %0d cycles, %0d errors", cycleLimit, errors);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		logic [127:0] key;
		logic [127:0] blk;
		logic [127:0] dir;
		logic [127:0] res;
		logic [127:0] back;
		int assertFails;
		rst = 1'b1;
		start = 1'b0;
		decrypt = 1'b0;
		keyIn = '0;
		blockIn = '0;
		buildModelTables();
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		runOp(knownKey, knownPt, 1'b0, -1, res);
		checkValue(res, knownCt, "known vector encrypt");
		runOp(knownKey, res, 1'b1, -1, back);
		checkValue(back, knownPt, "known vector decrypt");

		for (int i = 0; i < numRandom; i++) begin
			takeBits(128, key);
			takeBits(128, blk);
			runOp(key, blk, 1'b0, -1, res);
			checkValue(res, encryptModel(key, blk), "random encrypt");
			runOp(key, res, 1'b1, -1, back);
			checkValue(back, blk, "round trip");
		end

		for (int i = 0; i < numRandom; i++) begin
			takeBits(128, key);
			takeBits(128, blk);
			runOp(key, blk, 1'b1, -1, res);
			checkValue(res, decryptModel(key, blk), "random decrypt");
		end

		// second start while busy must be dropped
		takeBits(128, key);
		takeBits(128, blk);
		takeBits(1, dir);
		runOp(key, blk, dir[0], 5, res);
		checkValue(res, dir[0] ? decryptModel(key, blk) : encryptModel(key, blk),
			"result with start while busy");
		repeat (30) begin
			@(negedge clk);
			checkValue(128'(done), 128'(0), "extra done after ignored start");
		end

		// reset in the crypt phase
		takeBits(128, key);
		takeBits(128, blk);
		startOp(key, blk, 1'b0);
		repeat (14) @(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		checkValue(128'(busy), 128'(0), "busy during reset");
		checkValue(blockOut, '0, "blockOut during reset");
		@(posedge clk);
		rst <= 1'b0;

		// reset on the edge that raises done
		startOp(key, blk, 1'b0);
		repeat (21) @(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		checkValue(128'(done), 128'(0), "done during reset");
		checkValue(blockOut, '0, "blockOut during reset at done");
		@(posedge clk);
		rst <= 1'b0;

		runOp(key, blk, 1'b0, -1, res);
		checkValue(res, encryptModel(key, blk), "encrypt after reset");

		assertFails = u_dut.uChk.failCount;
		$display("checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, assertFails);
		if (errors == 0 && assertFails == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: dv/aesCore_chk.sv
`timescale 1ns/1ps

module aesCoreChk (
	input logic clk,
	input logic rst,
	input logic start,
	input logic busy,
	input logic done
);

	int failCount = 0;

	doneNotBusy: assert property (@(posedge clk) disable iff (rst) !(done && busy))
		else begin
			failCount++;
			$error("done and busy high together");
		end

	doneOneCycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else begin
			failCount++;
			$error("done held for more than one cycle");
		end

	// accepted at edge k and done raised by edge k+21
	startToDone: assert property (@(posedge clk) disable iff (rst)
		start && !busy |=> ##21 done)
		else begin
			failCount++;
			$error("done did not follow an accepted start after 21 edges");
		end

	busyInFlight: assert property (@(posedge clk) disable iff (rst)
		start && !busy |=> busy [*21] ##1 !busy)
		else begin
			failCount++;
			$error("busy not held for the whole operation");
		end

endmodule

bind aesCore aesCoreChk uChk (
	.clk(clk),
	.rst(rst),
	.start(start),
	.busy(busy),
	.done(done)
);

// File: hdl/aesCore.sv
`timescale 1ns/1ps

module aesCore (
	input logic clk,
	input logic rst,
	input logic start,
	input logic decrypt,
	input aesPkg::blockT keyIn,
	input aesPkg::blockT blockIn,
	output aesPkg::blockT blockOut,
	output logic busy,
	output logic done
);

	aesRoundIf rif ();

	aesControl uControl (
		.clk(clk),
		.rst(rst),
		.start(start),
		.decrypt(decrypt),
		.busy(busy),
		.done(done),
		.rif(rif)
	);

	// round keys 0 to 10, read by index
	aesKeySchedule uKeySchedule (
		.clk(clk),
		.rst(rst),
		.keyIn(keyIn),
		.rif(rif)
	);

	aesRoundEngine uRoundEngine (
		.clk(clk),
		.rst(rst),
		.blockIn(blockIn),
		.blockOut(blockOut),
		.rif(rif)
	);

endmodule

// File: hdl/aesRoundEngine.sv
`timescale 1ns/1ps

module aesRoundEngine (
	input logic clk,
	input logic rst,
	input aesPkg::blockT blockIn,
	output aesPkg::blockT blockOut,
	aesRoundIf.engine rif
);
	import aesPkg::*;

	blockT pending;
	blockT stateReg;
	blockT encOut;
	blockT decOut;

	aesEncRound uEncRound (
		.stateIn(stateReg),
		.roundKey(rif.roundKey),
		.lastRound(rif.lastRound),
		.stateOut(encOut)
	);

	aesDecRound uDecRound (
		.stateIn(stateReg),
		.roundKey(rif.roundKey),
		.lastRound(rif.lastRound),
		.stateOut(decOut)
	);

	// block waits here while the keys are expanded
	always_ff @(posedge clk) begin
		if (rif.load) begin
			pending <= blockIn;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			stateReg <= '0;
		end else if (rif.step) begin
			if (rif.whiten) begin
				stateReg <= pending ^ rif.roundKey;
			end else if (rif.decrypt) begin
				stateReg <= decOut;
			end else begin
				stateReg <= encOut;
			end
		end
	end

	assign blockOut = stateReg;

endmodule

// File: hdl/aesKeySchedule.sv
`timescale 1ns/1ps

module aesKeySchedule (
	input logic clk,
	input logic rst,
	input aesPkg::blockT keyIn,
	aesRoundIf.keys rif
);
	import aesPkg::*;

	blockT keyTable [numRounds + 1];
	byteT rcon;
	roundT prevIdx;
	blockT prevKey;
	blockT nextKey;
	wordT rotWord;
	wordT subWord;
	wordT chain;

	// during expansion roundIdx names the entry being written
	assign prevIdx = rif.roundIdx - roundT'(1);
	assign prevKey = keyTable[prevIdx];

	always_comb begin
		rotWord = {prevKey[23:0], prevKey[31:24]};
		for (int b = 0; b < 4; b++) begin
			subWord[8*b +: 8] = sbox(rotWord[8*b +: 8]);
		end
		chain = subWord ^ {rcon, 24'h000000};
		// w[i] = w[i-4] ^ w[i-1], word 0 in the top bits
		for (int i = 0; i < keyWords; i++) begin
			chain = chain ^ prevKey[127 - 32*i -: 32];
			nextKey[127 - 32*i -: 32] = chain;
		end
	end

	always_ff @(posedge clk) begin
		if (rif.load) begin
			keyTable[0] <= keyIn;
		end
		if (rif.expand) begin
			keyTable[rif.roundIdx] <= nextKey;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rcon <= rconInit;
		end else if (rif.load) begin
			rcon <= rconInit;
		end else if (rif.expand) begin
			rcon <= xtime(rcon);
		end
	end

	assign rif.roundKey = keyTable[rif.roundIdx];

endmodule

// File: hdl/aesControl.sv
`timescale 1ns/1ps

module aesControl (
	input logic clk,
	input logic rst,
	input logic start,
	input logic decrypt,
	output logic busy,
	output logic done,
	aesRoundIf.ctrl rif
);
	import aesPkg::*;

	typedef enum logic [1:0] {
		idle,
		expand,
		crypt
	} stateT;

	stateT state;
	roundT cnt;
	roundT cntNext;
	logic decLat;

	assign cntNext = cnt + roundT'(1);

	// key and block are captured on the accepted start edge itself
	assign rif.load = start && (state == idle);
	assign rif.decrypt = decLat;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= idle;
			cnt <= '0;
			decLat <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			rif.expand <= 1'b0;
			rif.step <= 1'b0;
			rif.whiten <= 1'b0;
			rif.lastRound <= 1'b0;
			rif.roundIdx <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				idle: begin
					if (start) begin
						state <= expand;
						cnt <= roundT'(1);
						decLat <= decrypt;
						busy <= 1'b1;
						rif.expand <= 1'b1;
						rif.roundIdx <= roundT'(1);
					end
				end
				expand: begin
					if (cnt == roundT'(numRounds)) begin
						state <= crypt;
						cnt <= '0;
						rif.expand <= 1'b0;
						rif.step <= 1'b1;
						rif.whiten <= 1'b1;
						// whitening key is the last one when decrypting
						rif.roundIdx <= decLat ? roundT'(numRounds) : '0;
					end else begin
						cnt <= cntNext;
						rif.roundIdx <= cntNext;
					end
				end
				crypt: begin
					if (cnt == roundT'(numRounds)) begin
						state <= idle;
						busy <= 1'b0;
						done <= 1'b1;
						rif.step <= 1'b0;
						rif.lastRound <= 1'b0;
					end else begin
						cnt <= cntNext;
						rif.whiten <= 1'b0;
						rif.lastRound <= (cntNext == roundT'(numRounds));
						rif.roundIdx <= decLat ? roundT'(numRounds) - cntNext : cntNext;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

endmodule

// File: hdl/aesDecRound.sv
`timescale 1ns/1ps

module aesDecRound (
	input aesPkg::blockT stateIn,
	input aesPkg::blockT roundKey,
	input logic lastRound,
	output aesPkg::blockT stateOut
);
	import aesPkg::*;

	blockT unshifted;
	blockT keyed;
	blockT mixed;

	// b[i] = 14a[i] ^ 11a[i+1] ^ 13a[i+2] ^ 9a[i+3]
	function automatic wordT invMixColumn(input wordT col);
		byteT a [4];
		wordT res;
		for (int i = 0; i < 4; i++) begin
			a[i] = col[31 - 8*i -: 8];
		end
		for (int i = 0; i < 4; i++) begin
			res[31 - 8*i -: 8] = gfMul(a[i], 8'h0e)
				^ gfMul(a[(i + 1) % 4], 8'h0b)
				^ gfMul(a[(i + 2) % 4], 8'h0d)
				^ gfMul(a[(i + 3) % 4], 8'h09);
		end
		return res;
	endfunction

	// row r rotates right by r, then the inverse substitution
	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				unshifted[127 - 8*(4*c + r) -: 8] =
					invSbox(stateIn[127 - 8*(4*((c - r + 4) % 4) + r) -: 8]);
			end
		end
	end

	assign keyed = unshifted ^ roundKey;

	always_comb begin
		for (int c = 0; c < 4; c++) begin
			mixed[127 - 32*c -: 32] = invMixColumn(keyed[127 - 32*c -: 32]);
		end
	end

	// final round has no InvMixColumns
	assign stateOut = lastRound ? keyed : mixed;

endmodule

// File: hdl/aesEncRound.sv
`timescale 1ns/1ps

module aesEncRound (
	input aesPkg::blockT stateIn,
	input aesPkg::blockT roundKey,
	input logic lastRound,
	output aesPkg::blockT stateOut
);
	import aesPkg::*;

	blockT shifted;
	blockT mixed;

	// b[i] = 2a[i] ^ 3a[i+1] ^ a[i+2] ^ a[i+3]
	function automatic wordT mixColumn(input wordT col);
		byteT a [4];
		wordT res;
		for (int i = 0; i < 4; i++) begin
			a[i] = col[31 - 8*i -: 8];
		end
		for (int i = 0; i < 4; i++) begin
			res[31 - 8*i -: 8] = xtime(a[i]) ^ xtime(a[(i + 1) % 4]) ^ a[(i + 1) % 4]
				^ a[(i + 2) % 4] ^ a[(i + 3) % 4];
		end
		return res;
	endfunction

	// byte n sits at row n%4, column n/4; row r rotates left by r
	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				shifted[127 - 8*(4*c + r) -: 8] =
					sbox(stateIn[127 - 8*(4*((c + r) % 4) + r) -: 8]);
			end
		end
	end

	always_comb begin
		for (int c = 0; c < 4; c++) begin
			mixed[127 - 32*c -: 32] = mixColumn(shifted[127 - 32*c -: 32]);
		end
	end

	assign stateOut = (lastRound ? shifted : mixed) ^ roundKey;

endmodule

// File: hdl/aesRoundIf.sv
`timescale 1ns/1ps

interface aesRoundIf;
	import aesPkg::*;

	// sequencing from the control FSM
	logic load;
	logic expand;
	logic step;
	logic whiten;
	logic lastRound;
	logic decrypt;
	roundT roundIdx;

	// table read at roundIdx
	blockT roundKey;

	modport ctrl (output load, expand, step, whiten, lastRound, roundIdx, decrypt);

	modport keys (input load, expand, roundIdx, output roundKey);

	modport engine (input load, step, whiten, lastRound, decrypt, roundKey);

endinterface

// File: hdl/aesPkg.sv
package aesPkg;

	typedef logic [7:0] byteT;
	typedef logic [31:0] wordT;
	typedef logic [127:0] blockT;
	typedef logic [3:0] roundT;

	localparam int numRounds = 10;
	localparam int keyWords = 4;

	// x^8 + x^4 + x^3 + x + 1 with the top bit dropped
	localparam byteT gfPoly = 8'h1b;

	// first Rcon byte, later ones come from xtime
	localparam byteT rconInit = 8'h01;

	localparam byteT affineConst = 8'h63;
	localparam byteT invAffineConst = 8'h05;

	function automatic byteT xtime(input byteT a);
		return {a[6:0], 1'b0} ^ (a[7] ? gfPoly : 8'h00);
	endfunction

	function automatic byteT gfMul(input byteT a, input byteT b);
		byteT acc;
		byteT sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < 8; i++) begin
			if (b[i]) begin
				acc = acc ^ sh;
			end
			sh = xtime(sh);
		end
		return acc;
	endfunction

	// a^254, which also maps zero to zero
	function automatic byteT gfInv(input byteT a);
		byteT sq;
		byteT acc;
		sq = a;
		acc = 8'h01;
		for (int i = 1; i < 8; i++) begin
			sq = gfMul(sq, sq);
			acc = gfMul(acc, sq);
		end
		return acc;
	endfunction

	function automatic byteT rotl8(input byteT a, input int n);
		return byteT'((a << n) | (a >> (8 - n)));
	endfunction

	function automatic byteT sbox(input byteT a);
		byteT inv;
		inv = gfInv(a);
		return inv ^ rotl8(inv, 1) ^ rotl8(inv, 2) ^ rotl8(inv, 3) ^ rotl8(inv, 4) ^ affineConst;
	endfunction

	// undo the affine map first, then invert
	function automatic byteT invSbox(input byteT a);
		byteT pre;
		pre = rotl8(a, 1) ^ rotl8(a, 3) ^ rotl8(a, 6) ^ invAffineConst;
		return gfInv(pre);
	endfunction

endpackage
